// ==== rtl/riscv_settings.svh ====
`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

// --------------------
// Core widths
// --------------------

`define RV_XLEN     32              // Data and address width
`define RV_NUM_REGS 32              // Integer register count
`define RV_REG_AW   5               // Register index width

// --------------------
// Reset state
// --------------------

`define RV_RESET_PC 32'h0000_0000   // First fetch address

`endif

// ==== rtl/riscv_pkg.sv ====
package riscv_pkg;

    // --------------------
    // Instruction word views
    // --------------------

    // Register-register layout, also used for I, B and J fields
    typedef struct packed {
        logic [6:0] funct7;         // Bits 31:25
        logic [4:0] rs2;            // Bits 24:20
        logic [4:0] rs1;            // Bits 19:15
        logic [2:0] funct3;         // Bits 14:12
        logic [4:0] rd;             // Bits 11:7
        logic [6:0] opcode;         // Bits 6:0
    } r_fmt_t;

    // Store layout with the split immediate
    typedef struct packed {
        logic [6:0] imm_hi;         // Imm[11:5]
        logic [4:0] rs2;            // Store data register
        logic [4:0] rs1;            // Base register
        logic [2:0] funct3;         // Access width
        logic [4:0] imm_lo;         // Imm[4:0]
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;              // Field view
        s_fmt_t s_fmt;              // Store immediate view
    } instr_u;

    // --------------------
    // Decode encodings
    // --------------------

    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,     // lw
        OP_STORE  = 7'b0100011,     // sw
        OP_OP     = 7'b0110011,     // R-type ALU
        OP_IMM    = 7'b0010011,     // I-type ALU
        OP_BRANCH = 7'b1100011,     // beq
        OP_JAL    = 7'b1101111      // jal
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101            // Signed compare
    } alu_op_e;

    typedef enum logic [1:0] {
        IMM_I = 2'b00,              // Loads and ALU immediates
        IMM_S = 2'b01,              // Stores
        IMM_B = 2'b10,              // Branches
        IMM_J = 2'b11               // jal
    } imm_src_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,            // ALU result
        RES_MEM = 2'b01,            // Load data
        RES_PC4 = 2'b10             // Link address
    } result_src_e;

endpackage

// ==== rtl/control_unit.sv ====
`timescale 1ns/100ps
module control_unit (
    input  riscv_pkg::instr_u      i_instr,      // Instruction under decode
    input  logic                   i_zero,       // ALU zero flag
    output logic                   o_pcsrc,      // Next PC from target adder
    output logic                   o_alusrc,     // Operand B from immediate
    output logic                   o_regwrite,   // Register writeback enable
    output logic                   o_mem_we,     // Data memory write strobe
    output riscv_pkg::result_src_e o_resultsrc,  // Writeback source
    output riscv_pkg::imm_src_e    o_immsrc,     // Immediate format
    output riscv_pkg::alu_op_e     o_alucontrol  // ALU operation
);

    import riscv_pkg::*;

    // ALU classes from the main decoder
    localparam logic [1:0] CLASS_ADD   = 2'b00;  // Address calculation
    localparam logic [1:0] CLASS_SUB   = 2'b01;  // Branch compare
    localparam logic [1:0] CLASS_FUNCT = 2'b10;  // From funct3/funct7

    opcode_e    l_opcode;
    logic [2:0] l_funct3;
    logic       l_funct7_b5;
    logic       l_rtype_sub;                    // R-type subtract
    logic       l_branch;
    logic       l_jump;
    logic [1:0] l_alu_class;

    assign l_opcode    = opcode_e'(i_instr.r_fmt.opcode);
    assign l_funct3    = i_instr.r_fmt.funct3;
    assign l_funct7_b5 = i_instr.r_fmt.funct7[5];
    assign l_rtype_sub = l_funct7_b5 && (l_opcode == OP_OP);  // addi ignores bit 30

    // --------------------
    // Main decoder
    // --------------------

    always_comb begin
        o_regwrite  = 1'b0;                     // No-op unless decoded
        o_mem_we    = 1'b0;
        o_alusrc    = 1'b0;
        o_resultsrc = RES_ALU;
        o_immsrc    = IMM_I;
        l_branch    = 1'b0;
        l_jump      = 1'b0;
        l_alu_class = CLASS_ADD;
        case (l_opcode)
            OP_LOAD: begin
                o_regwrite  = 1'b1;
                o_alusrc    = 1'b1;             // Base plus offset
                o_resultsrc = RES_MEM;
            end
            OP_STORE: begin
                o_mem_we    = 1'b1;
                o_alusrc    = 1'b1;
                o_immsrc    = IMM_S;
            end
            OP_OP: begin
                o_regwrite  = 1'b1;
                l_alu_class = CLASS_FUNCT;
            end
            OP_IMM: begin
                o_regwrite  = 1'b1;
                o_alusrc    = 1'b1;
                l_alu_class = CLASS_FUNCT;
            end
            OP_BRANCH: begin
                o_immsrc    = IMM_B;
                l_branch    = (l_funct3 == 3'b000);  // beq only
                l_alu_class = CLASS_SUB;
            end
            OP_JAL: begin
                o_regwrite  = 1'b1;
                o_resultsrc = RES_PC4;          // Link register gets PC+4
                o_immsrc    = IMM_J;
                l_jump      = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // --------------------
    // ALU decoder
    // --------------------

    always_comb begin
        case (l_alu_class)
            CLASS_ADD: o_alucontrol = ALU_ADD;
            CLASS_SUB: o_alucontrol = ALU_SUB;
            default: begin
                case (l_funct3)
                    3'b000:  o_alucontrol = l_rtype_sub ? ALU_SUB : ALU_ADD;
                    3'b010:  o_alucontrol = ALU_SLT;
                    3'b110:  o_alucontrol = ALU_OR;
                    3'b111:  o_alucontrol = ALU_AND;
                    default: o_alucontrol = ALU_ADD;  // Unsupported funct3
                endcase
            end
        endcase
    end

    assign o_pcsrc = l_jump || (l_branch && i_zero);  // Taken beq or jal

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/100ps
`include "riscv_settings.svh"
module register_file (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_reg_write,  // Write enable
    input  logic [`RV_REG_AW-1:0] i_rs1_addr,   // Read port 1 index
    input  logic [`RV_REG_AW-1:0] i_rs2_addr,   // Read port 2 index
    input  logic [`RV_REG_AW-1:0] i_rd_addr,    // Write port index
    input  logic [`RV_XLEN-1:0]   i_rd_data,    // Write data
    output logic [`RV_XLEN-1:0]   o_rs1_data,
    output logic [`RV_XLEN-1:0]   o_rs2_data
);

    logic [`RV_XLEN-1:0] l_regs [`RV_NUM_REGS];  // Architectural registers

    // Write port, x0 never written
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                l_regs[i] <= '0;                // All registers cleared
            end
        end else if (i_reg_write && (i_rd_addr != '0)) begin
            l_regs[i_rd_addr] <= i_rd_data;
        end
    end

    // Combinational reads
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : l_regs[i_rs1_addr];  // x0 reads zero
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : l_regs[i_rs2_addr];

endmodule

// ==== rtl/imm_extend.sv ====
`timescale 1ns/100ps
`include "riscv_settings.svh"
module imm_extend (
    input  riscv_pkg::instr_u   i_instr,   // Instruction word
    input  riscv_pkg::imm_src_e i_immsrc,  // Immediate format
    output logic [`RV_XLEN-1:0] o_immext   // Sign-extended immediate
);

    import riscv_pkg::*;

    logic l_sign;                          // Instruction bit 31

    assign l_sign = i_instr.r_fmt.funct7[6];

    always_comb begin
        case (i_immsrc)
            IMM_I: o_immext = {{(`RV_XLEN-12){l_sign}},
                               i_instr.r_fmt.funct7, i_instr.r_fmt.rs2};
            IMM_S: o_immext = {{(`RV_XLEN-12){l_sign}},
                               i_instr.s_fmt.imm_hi, i_instr.s_fmt.imm_lo};  // Split field
            IMM_B: o_immext = {{(`RV_XLEN-12){l_sign}},
                               i_instr.r_fmt.rd[0],         // Imm[11]
                               i_instr.r_fmt.funct7[5:0],   // Imm[10:5]
                               i_instr.r_fmt.rd[4:1],       // Imm[4:1]
                               1'b0};
            IMM_J: o_immext = {{(`RV_XLEN-20){l_sign}},
                               i_instr.r_fmt.rs1,           // Imm[19:15]
                               i_instr.r_fmt.funct3,        // Imm[14:12]
                               i_instr.r_fmt.rs2[0],        // Imm[11]
                               i_instr.r_fmt.funct7[5:0],   // Imm[10:5]
                               i_instr.r_fmt.rs2[4:1],      // Imm[4:1]
                               1'b0};
            default: o_immext = '0;
        endcase
    end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/100ps
`include "riscv_settings.svh"
module alu (
    input  logic [`RV_XLEN-1:0] i_a,           // rs1 operand
    input  logic [`RV_XLEN-1:0] i_b,           // rs2 or immediate
    input  riscv_pkg::alu_op_e  i_alucontrol,  // Operation select
    output logic [`RV_XLEN-1:0] o_result,
    output logic                o_zero         // Result is all zeros
);

    import riscv_pkg::*;

    logic [`RV_XLEN-1:0] l_sum;
    logic [`RV_XLEN-1:0] l_diff;
    logic                l_lt;                 // Signed less-than

    assign l_sum  = i_a + i_b;
    assign l_diff = i_a - i_b;
    assign l_lt   = $signed(i_a) < $signed(i_b);

    // --------------------
    // Operation select
    // --------------------

    always_comb begin
        case (i_alucontrol)
            ALU_ADD: o_result = l_sum;
            ALU_SUB: o_result = l_diff;        // Also beq compare
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_SLT: o_result = {{(`RV_XLEN-1){1'b0}}, l_lt};  // 1 or 0
            default: o_result = '0;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

// ==== rtl/datapath.sv ====
`timescale 1ns/100ps
`include "riscv_settings.svh"
module datapath (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_pcsrc,       // Take target adder output
    input  logic                   i_alusrc,      // Operand B from immediate
    input  logic                   i_regwrite,    // Writeback enable
    input  riscv_pkg::result_src_e i_resultsrc,   // Writeback source
    input  riscv_pkg::imm_src_e    i_immsrc,      // Immediate format
    input  riscv_pkg::alu_op_e     i_alucontrol,  // ALU operation
    input  riscv_pkg::instr_u      i_instr,       // Current instruction
    input  logic [`RV_XLEN-1:0]    i_readdata,    // Load data from memory
    output logic                   o_zero,        // ALU zero flag
    output logic [`RV_XLEN-1:0]    o_pc,          // Fetch address
    output logic [`RV_XLEN-1:0]    o_aluresult,   // Also the memory address
    output logic [`RV_XLEN-1:0]    o_writedata    // rs2, the store data
);

    import riscv_pkg::*;

    logic [`RV_XLEN-1:0] l_pc_next;
    logic [`RV_XLEN-1:0] l_pc_plus4;
    logic [`RV_XLEN-1:0] l_pc_target;             // Branch or jump target
    logic [`RV_XLEN-1:0] l_immext;
    logic [`RV_XLEN-1:0] l_src_a;
    logic [`RV_XLEN-1:0] l_src_b;
    logic [`RV_XLEN-1:0] l_result;                // Writeback value

    // --------------------
    // Program counter
    // --------------------

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc <= `RV_RESET_PC;
        end else begin
            o_pc <= l_pc_next;                    // One instruction per clock
        end
    end

    assign l_pc_plus4  = o_pc + `RV_XLEN'd4;
    assign l_pc_target = o_pc + l_immext;         // B or J offset
    assign l_pc_next   = i_pcsrc ? l_pc_target : l_pc_plus4;

    // --------------------
    // Register file and immediate
    // --------------------

    register_file u_register_file (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_reg_write (i_regwrite),
        .i_rs1_addr  (i_instr.r_fmt.rs1),
        .i_rs2_addr  (i_instr.r_fmt.rs2),
        .i_rd_addr   (i_instr.r_fmt.rd),          // Ignored on stores and branches
        .i_rd_data   (l_result),
        .o_rs1_data  (l_src_a),
        .o_rs2_data  (o_writedata)
    );

    imm_extend u_imm_extend (
        .i_instr  (i_instr),
        .i_immsrc (i_immsrc),
        .o_immext (l_immext)
    );

    // --------------------
    // Execute
    // --------------------

    assign l_src_b = i_alusrc ? l_immext : o_writedata;  // Immediate or rs2

    alu u_alu (
        .i_a          (l_src_a),
        .i_b          (l_src_b),
        .i_alucontrol (i_alucontrol),
        .o_result     (o_aluresult),
        .o_zero       (o_zero)
    );

    // Writeback select
    always_comb begin
        case (i_resultsrc)
            RES_ALU: l_result = o_aluresult;
            RES_MEM: l_result = i_readdata;      // lw
            RES_PC4: l_result = l_pc_plus4;      // jal link
            default: l_result = o_aluresult;
        endcase
    end

endmodule

// ==== rtl/riscv_core.sv ====
`timescale 1ns/100ps
`include "riscv_settings.svh"
module riscv_core (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic [`RV_XLEN-1:0] i_instr,      // Fetched word for o_pc
    input  logic [`RV_XLEN-1:0] i_mem_rdata,  // Same-cycle load data
    output logic [`RV_XLEN-1:0] o_pc,         // Fetch address
    output logic [`RV_XLEN-1:0] o_mem_addr,
    output logic [`RV_XLEN-1:0] o_mem_wdata,
    output logic                o_mem_we      // Taken at the rising edge
);

    import riscv_pkg::*;

    instr_u      l_instr;                     // Decoded views of i_instr
    logic        l_pcsrc;
    logic        l_alusrc;
    logic        l_regwrite;
    logic        l_zero;
    result_src_e l_resultsrc;
    imm_src_e    l_immsrc;
    alu_op_e     l_alucontrol;

    assign l_instr = instr_u'(i_instr);

    // --------------------
    // Decode
    // --------------------

    control_unit u_control_unit (
        .i_instr      (l_instr),
        .i_zero       (l_zero),
        .o_pcsrc      (l_pcsrc),
        .o_alusrc     (l_alusrc),
        .o_regwrite   (l_regwrite),
        .o_mem_we     (o_mem_we),
        .o_resultsrc  (l_resultsrc),
        .o_immsrc     (l_immsrc),
        .o_alucontrol (l_alucontrol)
    );

    // --------------------
    // Execute and writeback
    // --------------------

    datapath u_datapath (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_pcsrc      (l_pcsrc),
        .i_alusrc     (l_alusrc),
        .i_regwrite   (l_regwrite),
        .i_resultsrc  (l_resultsrc),
        .i_immsrc     (l_immsrc),
        .i_alucontrol (l_alucontrol),
        .i_instr      (l_instr),
        .i_readdata   (i_mem_rdata),
        .o_zero       (l_zero),
        .o_pc         (o_pc),
        .o_aluresult  (o_mem_addr),           // Load and store address
        .o_writedata  (o_mem_wdata)           // rs2 for sw
    );

endmodule

// ==== testbench/tb_riscv_core.sv ====
`timescale 1ns/100ps
`include "riscv_settings.svh"
module tb_riscv_core;

    localparam int CLK_PERIOD   = 4;        // ns
    localparam int RESET_CYCLES = 4;
    localparam int RUN_CYCLES   = 3000;
    localparam int PROG_WORDS   = 256;      // Instruction memory depth
    localparam int DATA_WORDS   = 64;       // Data area, word addressed
    localparam int WATCHDOG_NS  = (RUN_CYCLES + RESET_CYCLES + 50) * CLK_PERIOD;

    logic                i_clk;
    logic                i_rst_n;
    logic [`RV_XLEN-1:0] i_instr;
    logic [`RV_XLEN-1:0] i_mem_rdata;
    logic [`RV_XLEN-1:0] o_pc;
    logic [`RV_XLEN-1:0] o_mem_addr;
    logic [`RV_XLEN-1:0] o_mem_wdata;
    logic                o_mem_we;

    integer      seed = 1761;               // Fixed stimulus seed
    logic [31:0] prog     [PROG_WORDS];     // Instruction memory model
    logic [31:0] dut_mem  [DATA_WORDS];     // Data memory seen by the DUT
    logic [31:0] m_mem    [DATA_WORDS];     // Reference data memory
    logic [31:0] m_regs   [32];             // Reference registers
    logic [31:0] m_pc;                      // Reference PC

    // Effects of the current instruction, from the reference model
    logic [31:0] e_next_pc;
    logic        e_wr;
    logic [4:0]  e_rd;
    logic [31:0] e_val;
    logic        e_store;
    logic        e_load;
    logic [31:0] e_addr;
    logic [31:0] e_wdata;

    // DUT write captured at the falling edge
    logic        w_en;
    logic [31:0] w_addr;
    logic [31:0] w_data;

    riscv_core i_riscv_core (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_instr     (i_instr),
        .i_mem_rdata (i_mem_rdata),
        .o_pc        (o_pc),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .o_mem_we    (o_mem_we)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // --------------------
    // Instruction encoders
    // --------------------

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};      // ALU immediates and lw
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] fill_word(input int addr);
        return (32'(addr) * 32'h9E37_79B1) ^ 32'h5A5A_0000;  // Every address bit counts
    endfunction

    // Reference ALU from the instruction set rules
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'b000:  return sub ? x - y : x + y;
            3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b110:  return x | y;
            3'b111:  return x & y;
            default: return x + y;
        endcase
    endfunction

    // --------------------
    // Program generator
    // --------------------

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          sel;
        int          t;
        int          delta;
        for (int i = 0; i < PROG_WORDS; i++) begin
            r   = $random(seed);
            r2  = $random(seed);
            rd  = {2'b00, r[14:12]};          // x0 to x7
            rs1 = {2'b00, r[17:15]};
            rs2 = {2'b00, r[20:18]};
            t     = (i + 1 + int'(r2[4:0])) % PROG_WORDS;  // Forward, wraps at the end
            delta = (t - i) * 4;
            case (r[3:0])
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd15: begin
                    sel = int'(r[10:8]) % 5;
                    case (sel)
                        0:       prog[i] = enc_r(7'b0000000, rs2, rs1, 3'b000, rd);
                        1:       prog[i] = enc_r(7'b0100000, rs2, rs1, 3'b000, rd);  // sub
                        2:       prog[i] = enc_r(7'b0000000, rs2, rs1, 3'b010, rd);
                        3:       prog[i] = enc_r(7'b0000000, rs2, rs1, 3'b110, rd);
                        default: prog[i] = enc_r(7'b0000000, rs2, rs1, 3'b111, rd);
                    endcase
                end
                4'd5, 4'd6, 4'd7: begin
                    case (r[9:8])
                        2'd0:    prog[i] = enc_i(r2[11:0], rs1, 3'b000, rd, 7'b0010011);
                        2'd1:    prog[i] = enc_i(r2[11:0], rs1, 3'b010, rd, 7'b0010011);
                        2'd2:    prog[i] = enc_i(r2[11:0], rs1, 3'b110, rd, 7'b0010011);
                        default: prog[i] = enc_i(r2[11:0], rs1, 3'b111, rd, 7'b0010011);
                    endcase
                end
                4'd8, 4'd9:   prog[i] = enc_i({4'b0, r2[5:0], 2'b00}, 5'd0, 3'b010, rd,
                                              7'b0000011);  // lw off(x0)
                4'd10, 4'd11: prog[i] = enc_s({4'b0, r2[5:0], 2'b00}, rs2, 5'd0);
                4'd12:        prog[i] = enc_b(13'(delta), r[11] ? rs1 : rs2, rs1);  // Often equal
                4'd13:        prog[i] = enc_j(21'(delta), rd);
                default:      prog[i] = {r2[31:7], 7'b0001011};  // Unsupported opcode
            endcase
        end
    endtask

    // --------------------
    // Reference model
    // --------------------

    task automatic predict_effects();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        ins   = prog[m_pc[9:2]];
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        e_next_pc = m_pc + 32'd4;           // Default fall-through
        e_wr      = 1'b0;
        e_rd      = ins[11:7];
        e_val     = '0;
        e_store   = 1'b0;
        e_load    = 1'b0;
        e_addr    = a + imm_i;
        e_wdata   = b;
        case (ins[6:0])
            7'b0110011: begin
                e_wr  = 1'b1;
                e_val = alu_ref(ins[14:12], ins[30], a, b);
            end
            7'b0010011: begin
                e_wr  = 1'b1;
                e_val = alu_ref(ins[14:12], 1'b0, a, imm_i);  // No subi
            end
            7'b0000011: begin
                e_wr   = 1'b1;
                e_load = 1'b1;
                e_val  = m_mem[e_addr[7:2]];
            end
            7'b0100011: begin
                e_store = 1'b1;
                e_addr  = a + imm_s;
            end
            7'b1100011: begin
                if (a == b) begin
                    e_next_pc = m_pc + imm_b;
                end
            end
            7'b1101111: begin
                e_wr      = 1'b1;
                e_val     = m_pc + 32'd4;   // Link
                e_next_pc = m_pc + imm_j;
            end
            default: begin
            end
        endcase
    endtask

    task automatic commit_model();
        if (e_store) begin
            m_mem[e_addr[7:2]] = e_wdata;
        end
        if (e_wr && (e_rd != 5'd0)) begin
            m_regs[e_rd] = e_val;           // x0 stays zero
        end
        m_pc = e_next_pc;
    endtask

    task automatic drive_inputs();
        logic [31:0] ins;
        logic [31:0] addr;
        ins  = prog[m_pc[9:2]];
        addr = m_regs[ins[19:15]] + {{20{ins[31]}}, ins[31:20]};  // Load address if lw
        i_instr     <= ins;
        i_mem_rdata <= dut_mem[addr[7:2]];
    endtask

    // --------------------
    // Checks
    // --------------------

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch in %s: expected %h, actual %h at %0t", name, exp, act, $time);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_outputs();
        assert (o_pc === m_pc) else report_mismatch("pc", m_pc, o_pc);
        assert (o_mem_we === e_store) else report_mismatch("mem_we", 32'(e_store), 32'(o_mem_we));
        if (e_store || e_load) begin
            assert (o_mem_addr === e_addr) else report_mismatch("mem_addr", e_addr, o_mem_addr);
        end
        if (e_store) begin
            assert (o_mem_wdata === e_wdata)
                else report_mismatch("mem_wdata", e_wdata, o_mem_wdata);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the run finished");
        $display("Some tests failed");
        $fatal(1);
    end

    initial begin
        i_rst_n     = 1'b0;
        i_instr     = '0;                   // Opcode 0 decodes as no-op
        i_mem_rdata = '0;
        w_en        = 1'b0;
        w_addr      = '0;
        w_data      = '0;
        m_pc        = `RV_RESET_PC;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < DATA_WORDS; i++) begin
            m_mem[i]   = fill_word(i * 4);
            dut_mem[i] = fill_word(i * 4);
        end
        build_program();
        repeat (RESET_CYCLES) begin
            @(negedge i_clk);
            assert (o_pc === `RV_RESET_PC) else report_mismatch("reset_pc", `RV_RESET_PC, o_pc);
            assert (o_mem_we === 1'b0) else report_mismatch("reset_mem_we", 32'd0, 32'(o_mem_we));
        end
        @(posedge i_clk);
        i_rst_n <= 1'b1;
        drive_inputs();
        repeat (RUN_CYCLES) begin
            @(negedge i_clk);               // Outputs settled mid-cycle
            predict_effects();
            check_outputs();
            w_en   = o_mem_we;
            w_addr = o_mem_addr;
            w_data = o_mem_wdata;
            @(posedge i_clk);
            if (w_en) begin
                dut_mem[w_addr[7:2]] = w_data;  // Memory takes the write at the edge
            end
            commit_model();
            drive_inputs();
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/riscv_pkg.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/imm_extend.sv
rtl/alu.sv
rtl/datapath.sv
rtl/riscv_core.sv
testbench/tb_riscv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_riscv_core \
    -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_riscv_core
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
